// File: hdl/fetch_macros.svh
`ifndef FETCH_MACROS_SVH
`define FETCH_MACROS_SVH

// boot address of the fetch pc
`define FETCH_RESET_PC 32'h1eceb000

// instruction queue entries
`define FETCH_QUEUE_DEPTH 16

// cache lines, power of two
`define ICACHE_SETS 8

`endif

// File: hdl/fetch_pkg.sv
`default_nettype none

package fetch_pkg;

    `include "fetch_macros.svh"

    typedef logic [31:0]  addr_t;  // byte address
    typedef logic [31:0]  word_t;  // one instruction
    typedef logic [63:0]  beat_t;  // one burst beat
    typedef logic [255:0] line_t;  // eight words

    // what the queue carries per instruction
    typedef struct packed {
        addr_t pc;
        word_t inst;
    } fetch_entry_t;

    typedef enum logic [1:0] {
        idle,
        lookup,
        refill,
        respond
    } icache_state_t;

endpackage

`default_nettype wire

// File: hdl/cacheline_adapter.sv
`timescale 1ns/1ps
`default_nettype none

module cacheline_adapter (
    input  wire logic             clk,
    input  wire logic             rst,

    input  wire fetch_pkg::addr_t bmem_raddr_i,
    input  wire fetch_pkg::beat_t bmem_rdata_i,
    input  wire logic             bmem_rvalid_i,

    output fetch_pkg::line_t      line_o,
    output logic                  line_valid_o
);

    logic [1:0] beat_cnt_q;
    logic       last_beat;

    assign last_beat = bmem_rvalid_i && (beat_cnt_q == 2'd3);

    always_ff @(posedge clk) begin
        if (rst) begin
            beat_cnt_q   <= '0;
            line_valid_o <= 1'b0;
        end else begin
            line_valid_o <= last_beat;  // one cycle after beat four
            if (last_beat) begin
                beat_cnt_q <= '0;
            end else if (bmem_rvalid_i) begin
                beat_cnt_q <= beat_cnt_q + 2'd1;
            end
        end
    end

    // beats may come in any order, slot picked by address
    always_ff @(posedge clk) begin
        if (bmem_rvalid_i) begin
            line_o[{bmem_raddr_i[4:3], 6'd0} +: 64] <= bmem_rdata_i;
        end
    end

    // a burst is exactly four beats
    a_no_fifth_beat: assert property (
        @(posedge clk) disable iff (rst)
        last_beat |=> !bmem_rvalid_i
    );

endmodule

`default_nettype wire

// File: hdl/icache.sv
`timescale 1ns/1ps
`default_nettype none
`include "fetch_macros.svh"

module icache (
    input  wire logic             clk,
    input  wire logic             rst,

    // fetch side
    input  wire fetch_pkg::addr_t addr_i,
    input  wire logic             req_i,
    output fetch_pkg::word_t      rdata_o,
    output logic                  resp_o,

    // memory side
    input  wire logic             bmem_ready_i,
    input  wire fetch_pkg::line_t line_i,
    input  wire logic             line_valid_i,
    output fetch_pkg::addr_t      bmem_addr_o,
    output logic                  bmem_read_o
);

    localparam int idx_w = $clog2(`ICACHE_SETS);
    localparam int tag_w = 27 - idx_w;  // 5 offset bits below the index

    typedef logic [idx_w-1:0] idx_t;
    typedef logic [tag_w-1:0] tag_t;

    fetch_pkg::icache_state_t state_q;
    fetch_pkg::addr_t         addr_q;

    fetch_pkg::line_t         data_q [`ICACHE_SETS];
    tag_t                     tag_q  [`ICACHE_SETS];
    logic [`ICACHE_SETS-1:0]  valid_q;

    idx_t       idx;
    tag_t       tag;
    logic [2:0] word_sel;
    logic       hit;
    logic       accept;

    assign idx      = addr_q[5 +: idx_w];
    assign tag      = addr_q[31 -: tag_w];
    assign word_sel = addr_q[4:2];
    assign hit      = valid_q[idx] && (tag_q[idx] == tag);

    // a new request is taken when idle or while answering the last one
    assign accept = req_i && (state_q == fetch_pkg::idle || state_q == fetch_pkg::respond);

    assign resp_o      = (state_q == fetch_pkg::respond);
    assign rdata_o     = data_q[idx][{word_sel, 5'd0} +: 32];
    assign bmem_addr_o = {addr_q[31:5], 5'd0};  // line aligned
    assign bmem_read_o = (state_q == fetch_pkg::lookup) && !hit && bmem_ready_i;

    always_ff @(posedge clk) begin
        if (rst) begin
            state_q <= fetch_pkg::idle;
            valid_q <= '0;
        end else begin
            case (state_q)
                fetch_pkg::idle: begin
                    if (req_i) begin
                        state_q <= fetch_pkg::lookup;
                    end
                end
                fetch_pkg::lookup: begin
                    if (hit) begin
                        state_q <= fetch_pkg::respond;
                    end else if (bmem_ready_i) begin
                        state_q <= fetch_pkg::refill;  // read pulsed this cycle
                    end
                end
                fetch_pkg::refill: begin
                    // back to lookup, which now hits on the new line
                    if (line_valid_i) begin
                        valid_q[idx] <= 1'b1;
                        state_q      <= fetch_pkg::lookup;
                    end
                end
                fetch_pkg::respond: begin
                    state_q <= req_i ? fetch_pkg::lookup : fetch_pkg::idle;
                end
                default: state_q <= fetch_pkg::idle;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            addr_q <= addr_i;
        end
        if (state_q == fetch_pkg::refill && line_valid_i) begin
            data_q[idx] <= line_i;
            tag_q[idx]  <= tag;
        end
    end

    // the fetch unit keeps one request in flight
    a_req_when_free: assert property (
        @(posedge clk) disable iff (rst)
        req_i |-> (state_q == fetch_pkg::idle || state_q == fetch_pkg::respond)
    );

    // a line showing up outside refill would be dropped
    a_line_in_refill: assert property (
        @(posedge clk) disable iff (rst)
        line_valid_i |-> (state_q == fetch_pkg::refill)
    );

endmodule

`default_nettype wire

// File: hdl/fetch_queue.sv
`timescale 1ns/1ps
`default_nettype none

module fetch_queue #(
    parameter int DEPTH = 16
) (
    input  wire logic                    clk,
    input  wire logic                    rst,

    input  wire fetch_pkg::fetch_entry_t wdata_i,
    input  wire logic                    enqueue_i,
    input  wire logic                    dequeue_i,

    output fetch_pkg::fetch_entry_t      rdata_o,
    output logic                         full_o,
    output logic                         almost_full_o,
    output logic                         empty_o
);

    localparam int ptr_w = $clog2(DEPTH);
    localparam int cnt_w = $clog2(DEPTH + 1);

    fetch_pkg::fetch_entry_t mem [DEPTH];

    logic [ptr_w-1:0] rd_ptr_q;
    logic [ptr_w-1:0] wr_ptr_q;
    logic [cnt_w-1:0] count_q;
    logic             do_deq;

    assign do_deq = dequeue_i && !empty_o;  // pop on empty is dropped

    assign rdata_o       = mem[rd_ptr_q];
    assign empty_o       = (count_q == '0);
    assign full_o        = (count_q == cnt_w'(DEPTH));
    assign almost_full_o = (count_q >= cnt_w'(DEPTH - 1));

    always_ff @(posedge clk) begin
        if (rst) begin
            rd_ptr_q <= '0;
            wr_ptr_q <= '0;
            count_q  <= '0;
        end else begin
            if (enqueue_i) begin
                wr_ptr_q <= (wr_ptr_q == ptr_w'(DEPTH - 1)) ? '0 : wr_ptr_q + 1'b1;
            end
            if (do_deq) begin
                rd_ptr_q <= (rd_ptr_q == ptr_w'(DEPTH - 1)) ? '0 : rd_ptr_q + 1'b1;
            end
            // both in one cycle leaves the count alone
            if (enqueue_i && !do_deq) begin
                count_q <= count_q + 1'b1;
            end else if (do_deq && !enqueue_i) begin
                count_q <= count_q - 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (enqueue_i) begin
            mem[wr_ptr_q] <= wdata_i;
        end
    end

    // producer has to hold off before the queue fills
    a_no_overflow: assert property (
        @(posedge clk) disable iff (rst)
        enqueue_i |-> !full_o
    );

endmodule

`default_nettype wire

// File: hdl/fetch_unit.sv
`timescale 1ns/1ps
`default_nettype none
`include "fetch_macros.svh"

module fetch_unit (
    input  wire logic             clk,
    input  wire logic             rst,

    // burst memory
    input  wire logic             bmem_ready_i,
    input  wire fetch_pkg::addr_t bmem_raddr_i,
    input  wire fetch_pkg::beat_t bmem_rdata_i,
    input  wire logic             bmem_rvalid_i,
    output fetch_pkg::addr_t      bmem_addr_o,
    output logic                  bmem_read_o,

    // instruction queue head
    input  wire logic             dequeue_i,
    output fetch_pkg::fetch_entry_t entry_o,
    output logic                  entry_valid_o
);

    fetch_pkg::addr_t pc_q;
    fetch_pkg::addr_t req_pc_q;     // pc of the word in flight
    logic             outstanding_q;

    logic             issue;
    logic             cache_resp;
    fetch_pkg::word_t cache_rdata;

    fetch_pkg::line_t line;
    logic             line_valid;

    fetch_pkg::fetch_entry_t push_entry;
    logic             q_almost_full;
    logic             q_empty;

    // keep a slot free for the word already requested
    assign issue = (!outstanding_q || cache_resp) && !q_almost_full;

    assign push_entry.pc   = req_pc_q;
    assign push_entry.inst = cache_rdata;

    assign entry_valid_o = !q_empty;

    always_ff @(posedge clk) begin
        if (rst) begin
            pc_q          <= `FETCH_RESET_PC;
            outstanding_q <= 1'b0;
        end else if (issue) begin
            pc_q          <= pc_q + 32'd4;
            outstanding_q <= 1'b1;
        end else if (cache_resp) begin
            outstanding_q <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (issue) begin
            req_pc_q <= pc_q;
        end
    end

    icache u_icache (
        .clk          (clk),
        .rst          (rst),
        .addr_i       (pc_q),
        .req_i        (issue),
        .rdata_o      (cache_rdata),
        .resp_o       (cache_resp),
        .bmem_ready_i (bmem_ready_i),
        .line_i       (line),
        .line_valid_i (line_valid),
        .bmem_addr_o  (bmem_addr_o),
        .bmem_read_o  (bmem_read_o)
    );

    cacheline_adapter u_cacheline_adapter (
        .clk           (clk),
        .rst           (rst),
        .bmem_raddr_i  (bmem_raddr_i),
        .bmem_rdata_i  (bmem_rdata_i),
        .bmem_rvalid_i (bmem_rvalid_i),
        .line_o        (line),
        .line_valid_o  (line_valid)
    );

    fetch_queue #(
        .DEPTH (`FETCH_QUEUE_DEPTH)
    ) u_fetch_queue (
        .clk           (clk),
        .rst           (rst),
        .wdata_i       (push_entry),
        .enqueue_i     (cache_resp),  // every response lands here
        .dequeue_i     (dequeue_i),
        .rdata_o       (entry_o),
        .full_o        (),
        .almost_full_o (q_almost_full),
        .empty_o       (q_empty)
    );

endmodule

`default_nettype wire

// File: tests/fetch_tb.sv
`timescale 1ns/1ps
`default_nettype none
`include "fetch_macros.svh"

module fetch_tb;

    localparam int num_insts  = 400;
    localparam int max_cycles = num_insts * 40;

    logic                    clk;
    logic                    rst;
    logic                    bmem_ready_i;
    fetch_pkg::addr_t        bmem_raddr_i;
    fetch_pkg::beat_t        bmem_rdata_i;
    logic                    bmem_rvalid_i;
    logic                    dequeue_i;
    fetch_pkg::addr_t        bmem_addr_o;
    logic                    bmem_read_o;
    fetch_pkg::fetch_entry_t entry_o;
    logic                    entry_valid_o;

    logic [31:0]      seed;
    int               cycle_cnt;
    int               checked;
    int               occupancy;   // entries the queue should hold
    int               max_occ;
    fetch_pkg::addr_t exp_pc;
    fetch_pkg::addr_t next_line;   // line the next read has to ask for
    logic             beat_seen;
    logic             rst_q;

    // burst memory model
    logic             burst_busy;
    fetch_pkg::addr_t burst_line;
    int               burst_wait;
    int               burst_idx;
    logic [1:0]       burst_order [4];

    fetch_unit u_fetch_unit (
        .clk           (clk),
        .rst           (rst),
        .bmem_ready_i  (bmem_ready_i),
        .bmem_raddr_i  (bmem_raddr_i),
        .bmem_rdata_i  (bmem_rdata_i),
        .bmem_rvalid_i (bmem_rvalid_i),
        .bmem_addr_o   (bmem_addr_o),
        .bmem_read_o   (bmem_read_o),
        .dequeue_i     (dequeue_i),
        .entry_o       (entry_o),
        .entry_valid_o (entry_valid_o)
    );

    always #5 clk = ~clk;

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    function automatic logic [31:0] next_rand();
        seed = lcg_next(seed);
        return seed;
    endfunction

    // instruction word stored at byte address a
    function automatic fetch_pkg::word_t mem_word(input fetch_pkg::addr_t a);
        logic [31:0] x;
        x = (a ^ 32'h6b2d_93e1) * 32'h9e37_79b9;
        return x ^ {x[15:0], x[31:16]} ^ a;
    endfunction

    function automatic fetch_pkg::beat_t mem_beat(input fetch_pkg::addr_t line_addr,
                                                  input logic [1:0] slot);
        fetch_pkg::addr_t a;
        a = line_addr + {27'd0, slot, 3'd0};
        return {mem_word(a + 32'd4), mem_word(a)};  // upper word is the higher address
    endfunction

    task automatic stop_with_error(input string text);
        $display("%s", text);
        $display("*** TEST FAILED ***");
        $fatal(1, "simulation stopped on error");
    endtask

    // random permutation of the four beat slots
    task automatic shuffle_order();
        logic [31:0] r;
        logic [1:0]  tmp;
        int          j;
        for (int k = 0; k < 4; k++) begin
            burst_order[k] = 2'(k);
        end
        for (int k = 3; k > 0; k--) begin
            r              = next_rand();
            j              = int'(r[31:16]) % (k + 1);
            tmp            = burst_order[k];
            burst_order[k] = burst_order[j];
            burst_order[j] = tmp;
        end
    endtask

    task automatic check_read_request();
        logic [31:0] r;
        if (bmem_read_o) begin
            assert (bmem_ready_i)
                else stop_with_error("read pulsed while memory was not ready");
            assert (!burst_busy)
                else stop_with_error("read pulsed before the previous burst was complete");
            assert (bmem_addr_o == next_line)
                else stop_with_error($sformatf("mismatch at %0t ns: read line %h, expected %h",
                                               $time, bmem_addr_o, next_line));
            next_line  = next_line + 32'd32;
            burst_busy = 1'b1;
            burst_line = bmem_addr_o;
            burst_idx  = 0;
            r          = next_rand();
            burst_wait = 1 + int'(r[31:16]) % 6;  // latency before first beat
            shuffle_order();
        end
    endtask

    task automatic check_dequeue();
        assert (!entry_valid_o || beat_seen)
            else stop_with_error("entry valid before any memory data arrived");
        if (dequeue_i && entry_valid_o) begin
            assert (entry_o.pc == exp_pc)
                else stop_with_error($sformatf("mismatch at %0t ns: pc %h, expected %h",
                                               $time, entry_o.pc, exp_pc));
            assert (entry_o.inst == mem_word(exp_pc))
                else stop_with_error($sformatf("mismatch at %0t ns: inst %h at pc %h, expected %h",
                                               $time, entry_o.inst, exp_pc, mem_word(exp_pc)));
            exp_pc  = exp_pc + 32'd4;
            checked = checked + 1;
        end
    endtask

    task automatic track_occupancy();
        assert (entry_valid_o == (occupancy != 0))
            else stop_with_error($sformatf("mismatch at %0t ns: entry_valid_o %b with %0d held",
                                           $time, entry_valid_o, occupancy));
        if (u_fetch_unit.cache_resp) begin
            occupancy = occupancy + 1;
        end
        if (dequeue_i && entry_valid_o) begin
            occupancy = occupancy - 1;
        end
        assert (occupancy <= `FETCH_QUEUE_DEPTH)
            else stop_with_error("queue holds more entries than its depth");
        if (occupancy > max_occ) begin
            max_occ = occupancy;
        end
    endtask

    task automatic drive_inputs();
        logic [31:0] r;
        r = next_rand();
        // long stretches without dequeue fill the queue
        if (cycle_cnt[8:7] == 2'b11) begin
            dequeue_i <= 1'b0;
        end else begin
            dequeue_i <= r[31];
        end
        bmem_ready_i  <= (r[30:29] != 2'b00);
        bmem_rvalid_i <= 1'b0;
        if (burst_busy) begin
            if (burst_wait > 0) begin
                burst_wait = burst_wait - 1;
            end else begin
                bmem_rvalid_i <= 1'b1;
                bmem_raddr_i  <= burst_line | {27'd0, burst_order[burst_idx], 3'd0};
                bmem_rdata_i  <= mem_beat(burst_line, burst_order[burst_idx]);
                beat_seen      = 1'b1;
                burst_idx      = burst_idx + 1;
                burst_wait     = int'(r[15:0]) % 3;  // gap to the next beat
                if (burst_idx == 4) begin
                    burst_busy = 1'b0;
                end
            end
        end
    endtask

    initial begin
        clk           = 1'b0;
        rst           = 1'b1;
        bmem_ready_i  = 1'b0;
        bmem_raddr_i  = '0;
        bmem_rdata_i  = '0;
        bmem_rvalid_i = 1'b0;
        dequeue_i     = 1'b0;
        seed          = 32'hf557_40d2;
        cycle_cnt     = 0;
        checked       = 0;
        occupancy     = 0;
        max_occ       = 0;
        exp_pc        = `FETCH_RESET_PC;
        next_line     = `FETCH_RESET_PC & ~32'h1f;
        beat_seen     = 1'b0;
        rst_q         = 1'b0;
        burst_busy    = 1'b0;
        burst_wait    = 0;
        burst_idx     = 0;
        repeat (4) @(posedge clk);
        rst <= 1'b0;
    end

    always @(posedge clk) begin
        cycle_cnt = cycle_cnt + 1;
        assert (cycle_cnt <= max_cycles)
            else stop_with_error($sformatf("timeout with %0d of %0d instructions checked",
                                           checked, num_insts));
        if (rst_q) begin
            assert (!bmem_read_o && !entry_valid_o)
                else stop_with_error("read or entry valid high right after reset");
        end
        if (!rst) begin
            check_read_request();
            track_occupancy();
            check_dequeue();
        end
        rst_q = rst;
        drive_inputs();
        if (checked == num_insts) begin
            if (max_occ >= `FETCH_QUEUE_DEPTH - 1) begin
                $display("*** TEST PASSED ***");
                $finish;
            end else begin
                $display("queue never filled up, back-pressure was not exercised");
                $display("*** TEST FAILED ***");
                $fatal(1, "back-pressure not reached");
            end
        end
    end

endmodule

`default_nettype wire

// File: sources.f
+incdir+hdl
hdl/fetch_pkg.sv
hdl/cacheline_adapter.sv
hdl/icache.sv
hdl/fetch_queue.sv
hdl/fetch_unit.sv
tests/fetch_tb.sv

// File: run.sh
#!/bin/sh
# compile and run the fetch front end testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --assert --timing -Wno-fatal \
    -f sources.f \
    --top-module fetch_tb \
    -Mdir obj_dir \
    -o fetch_tb
status=$?
if [ "$status" -ne 0 ]; then
    echo "verilator build failed with status $status"
    exit "$status"
fi

./obj_dir/fetch_tb
status=$?
if [ "$status" -ne 0 ]; then
    echo "simulation failed with status $status"
    exit "$status"
fi

echo "simulation finished cleanly"
exit 0
